/* rtl/rec_defs.svh */
`ifndef REC_DEFS_SVH
`define REC_DEFS_SVH

// ----------------------------------------------------------------------
// video path sizes
// ----------------------------------------------------------------------
`define REC_PIX_LANES    10        // pixels per clk from the camera block
`define REC_PIX_W        8
`define REC_FIFO_DEPTH   16        // video buffer entries
`define REC_ADDR_W       24        // storage word address
`define REC_CNT_W        12        // frame and drop counters

// ----------------------------------------------------------------------
// user register channel
// ----------------------------------------------------------------------
`define REC_CMD_ADDR_W   4         // upper bits of the 16-bit write word
`define REC_CMD_DATA_W   12
`define REC_LIMIT_W      8         // frame limit, 0 = unlimited

`define REC_REG_CTRL     4'd0
`define REC_REG_FRAMES   4'd1
`define REC_REG_DROPS    4'd2

// CTRL data layout
`define REC_CTRL_EN_BIT  0         // record enable
`define REC_CTRL_LIM_LSB 4         // limit in data[11:4]

`endif

/* rtl/rec_pkg.sv */
`include "rec_defs.svh"

package rec_pkg;

    // ------------------------------------------------------------------
    // video stream
    // ------------------------------------------------------------------
    // lane 0 in the low byte
    typedef logic [`REC_PIX_LANES-1:0][`REC_PIX_W-1:0] pix_group_t;

    typedef struct packed {
        logic       sof;            // first group of a frame
        logic       sol;            // first group of a line
        pix_group_t pix;
    } vid_word_t;                   // 82 bits

    // one beat toward the storage sink
    typedef struct packed {
        logic [`REC_ADDR_W-1:0] addr;
        vid_word_t              word;
    } rec_beat_t;

    // ------------------------------------------------------------------
    // user channel
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`REC_CMD_ADDR_W-1:0] addr;   // register select
        logic [`REC_CMD_DATA_W-1:0] data;
    } cfg_cmd_t;

    typedef struct packed {
        logic                    en;
        logic [`REC_LIMIT_W-1:0] limit;
    } rec_ctrl_t;

    // status byte, bit 0 is recording
    typedef struct packed {
        logic [3:0] rsvd;           // reads zero
        logic       limit_hit;
        logic       empty;          // video buffer empty
        logic       ovf_seen;       // sticky until next enable
        logic       recording;
    } rec_stat_t;

endpackage

/* rtl/video_capture.sv */
`timescale 1ns/100ps
`include "rec_defs.svh"

module video_capture import rec_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  pix_group_t            i_pix,
    input  logic                  i_fval,
    input  logic                  i_lval,
    input  rec_ctrl_t             i_ctrl,
    input  logic                  i_ctrl_wr,     // enable write pulse
    output vid_word_t             o_word,
    output logic                  o_word_valid,
    input  logic                  i_word_ready,
    output logic [`REC_CNT_W-1:0] o_frames,
    output logic [`REC_CNT_W-1:0] o_drops,
    output logic                  o_recording,
    output logic                  o_limit_hit
);

    typedef enum logic [1:0] {ST_IDLE, ST_ARMED, ST_REC, ST_STOP} cap_state_t;

    cap_state_t state;
    logic       fval_q;
    logic       sof_pend;       // next valid group opens a frame
    logic       sol_pend;       // next valid group opens a line
    logic       grp_valid;
    logic       frame_end;
    logic       at_limit;
    logic       take;           // group goes out as a stream word

    assign grp_valid = i_fval & i_lval;
    assign frame_end = fval_q & ~i_fval;   // falling fval
    assign at_limit  = (i_ctrl.limit != '0) &&
                       (o_frames == `REC_CNT_W'(i_ctrl.limit));

    // armed waits for a frame start, never joins mid-frame
    assign take = grp_valid &&
                  ((state == ST_REC) || (state == ST_ARMED && i_ctrl.en && sof_pend));

    assign o_recording = (state == ST_ARMED) || (state == ST_REC);

    // ------------------------------------------------------------------
    // strobe edges, gating FSM, counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            fval_q       <= 1'b0;
            sof_pend     <= 1'b0;    // no start flag if reset lands mid-frame
            sol_pend     <= 1'b0;
            o_word_valid <= 1'b0;
            o_frames     <= '0;
            o_drops      <= '0;
            o_limit_hit  <= 1'b0;
        end else begin
            fval_q <= i_fval;
            if (!i_fval)
                sof_pend <= 1'b1;
            else if (grp_valid)
                sof_pend <= 1'b0;
            if (!i_lval)
                sol_pend <= 1'b1;
            else if (grp_valid)
                sol_pend <= 1'b0;

            o_word_valid <= take;
            if (o_word_valid && !i_word_ready)
                o_drops <= o_drops + 1'b1;   // buffer full, word lost

            case (state)
                ST_IDLE, ST_STOP: begin
                    if (i_ctrl_wr && i_ctrl.en)
                        state <= ST_ARMED;
                end
                ST_ARMED: begin
                    if (!i_ctrl.en) begin
                        state <= ST_IDLE;
                    end else if (take) begin
                        state    <= ST_REC;
                        o_frames <= o_frames + 1'b1;
                    end
                end
                ST_REC: begin
                    // decide only on whole-frame boundaries
                    if (frame_end) begin
                        if (!i_ctrl.en) begin
                            state <= ST_IDLE;
                        end else if (at_limit) begin
                            state       <= ST_STOP;
                            o_limit_hit <= 1'b1;
                        end else begin
                            state <= ST_ARMED;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (i_ctrl_wr && i_ctrl.en) begin   // fresh run
                o_frames    <= '0;
                o_drops     <= '0;
                o_limit_hit <= 1'b0;
            end
        end
    end

    // stream word, flags qualified by take
    always_ff @(posedge clk) begin
        o_word.pix <= i_pix;
        o_word.sof <= take & sof_pend;
        o_word.sol <= take & sol_pend;
    end

    // a frame's first word opens a line too
    a_sof_sol: assert property (@(posedge clk) disable iff (i_reset)
        (o_word_valid && o_word.sof) |-> o_word.sol);

endmodule

/* rtl/stream_fifo.sv */
`timescale 1ns/100ps

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 16
) (
    input  logic clk,
    input  logic i_reset,
    input  T     i_data,
    input  logic i_valid,
    output logic o_ready,
    output T     o_data,
    output logic o_valid,
    input  logic i_ready,
    output logic o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL   = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_P = PTR_W'(DEPTH - 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;      // occupancy
    logic             push;
    logic             pop;

    assign o_ready = (count != FULL);   // full stays full even with a pop
    assign o_empty = (count == '0);
    assign o_valid = ~o_empty;
    assign o_data  = mem[rd_ptr];       // head, stable until popped
    assign push    = i_valid & o_ready;
    assign pop     = o_valid & i_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= i_data;
    end

    // ------------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_P) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_P) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (i_reset)
        count <= FULL);

    // full and empty both leave the pointers level
    a_ptr_level: assert property (@(posedge clk) disable iff (i_reset)
        (o_empty || count == FULL) |-> (wr_ptr == rd_ptr));

endmodule

/* rtl/usr_ctrl_regs.sv */
`timescale 1ns/100ps
`include "rec_defs.svh"

module usr_ctrl_regs import rec_pkg::*; (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_usr_tx_wr,
    input  logic                  i_usr_rx_rd,
    input  cfg_cmd_t              i_usr_txd,
    output logic [15:0]           o_usr_rxd,
    output rec_stat_t             o_usr_status,
    output rec_ctrl_t             o_ctrl,
    output logic                  o_ctrl_wr,     // pulse on a write that sets enable
    input  logic [`REC_CNT_W-1:0] i_frames,
    input  logic [`REC_CNT_W-1:0] i_drops,
    input  logic                  i_recording,
    input  logic                  i_limit_hit,
    input  logic                  i_fifo_empty
);

    logic                      ctrl_sel;
    logic [`REC_CNT_W-1:0]     drops_q;
    logic                      ovf_seen;
    logic [`REC_CMD_DATA_W-1:0] ctrl_rd;    // CTRL as written

    assign ctrl_sel = i_usr_tx_wr && (i_usr_txd.addr == `REC_REG_CTRL);

    // ------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ctrl    <= '0;
            o_ctrl_wr <= 1'b0;
        end else begin
            o_ctrl_wr <= ctrl_sel && i_usr_txd.data[`REC_CTRL_EN_BIT];
            if (ctrl_sel) begin
                o_ctrl.en    <= i_usr_txd.data[`REC_CTRL_EN_BIT];
                o_ctrl.limit <= i_usr_txd.data[`REC_CTRL_LIM_LSB +: `REC_LIMIT_W];
            end
        end
    end

    // sticky overflow
    // a move to zero is the counter clearing, not a drop
    always_ff @(posedge clk) begin
        if (i_reset) begin
            drops_q  <= '0;
            ovf_seen <= 1'b0;
        end else begin
            drops_q <= i_drops;
            if (o_ctrl_wr)
                ovf_seen <= 1'b0;
            else if (i_drops != drops_q && i_drops != '0)
                ovf_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[`REC_CTRL_EN_BIT] = o_ctrl.en;
        ctrl_rd[`REC_CTRL_LIM_LSB +: `REC_LIMIT_W] = o_ctrl.limit;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_usr_rxd <= '0;
        end else if (i_usr_rx_rd) begin      // held until next read
            case (i_usr_txd.addr)
                `REC_REG_CTRL:   o_usr_rxd <= 16'(ctrl_rd);
                `REC_REG_FRAMES: o_usr_rxd <= 16'(i_frames);
                `REC_REG_DROPS:  o_usr_rxd <= 16'(i_drops);
                default:         o_usr_rxd <= '0;   // unmapped
            endcase
        end
    end

    // live status byte
    always_comb begin
        o_usr_status           = '0;
        o_usr_status.recording = i_recording;
        o_usr_status.ovf_seen  = ovf_seen;
        o_usr_status.empty     = i_fifo_empty;
        o_usr_status.limit_hit = i_limit_hit;
    end

endmodule

/* rtl/rec_writer.sv */
`timescale 1ns/100ps
`include "rec_defs.svh"

module rec_writer import rec_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,
    input  logic      i_start,        // enable write, restart addresses
    input  vid_word_t i_word,
    input  logic      i_word_valid,
    output logic      o_word_ready,
    output rec_beat_t o_rec,
    output logic      o_rec_valid,
    input  logic      i_rec_ready
);

    logic [`REC_ADDR_W-1:0] addr_q;       // next address to hand out
    logic [`REC_ADDR_W-1:0] addr_base;
    logic                   load;

    // one slot, refilled in the cycle its beat leaves
    assign o_word_ready = ~o_rec_valid | i_rec_ready;
    assign load         = i_word_valid & o_word_ready;
    assign addr_base    = i_start ? '0 : addr_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rec_valid <= 1'b0;
            addr_q      <= '0;
        end else begin
            if (load) begin
                o_rec_valid <= 1'b1;
                addr_q      <= addr_base + 1'b1;
            end else begin
                if (i_rec_ready)
                    o_rec_valid <= 1'b0;   // beat taken, nothing behind it
                addr_q <= addr_base;
            end
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (load) begin
            o_rec.addr <= addr_base;
            o_rec.word <= i_word;
        end
    end

    // sink sees a steady beat under back-pressure
    a_hold_beat: assert property (@(posedge clk) disable iff (i_reset)
        (o_rec_valid && !i_rec_ready) |=> (o_rec_valid && $stable(o_rec)));

endmodule

/* rtl/rec_top.sv */
`timescale 1ns/100ps
`include "rec_defs.svh"

module rec_top import rec_pkg::*; (
    input  logic       clk,
    input  logic       i_reset,
    // camera
    input  pix_group_t i_pix,
    input  logic       i_fval,
    input  logic       i_lval,
    // record port toward storage
    output rec_beat_t  o_rec,
    output logic       o_rec_valid,
    input  logic       i_rec_ready,
    // user register channel
    input  logic       i_usr_tx_wr,
    input  logic       i_usr_rx_rd,
    input  cfg_cmd_t   i_usr_txd,
    output logic [15:0] o_usr_rxd,
    output rec_stat_t  o_usr_status
);

    vid_word_t             cap_word;
    logic                  cap_valid;
    logic                  cap_ready;
    vid_word_t             buf_word;
    logic                  buf_valid;
    logic                  buf_ready;
    logic                  fifo_empty;
    rec_ctrl_t             ctrl;
    logic                  ctrl_wr;
    logic [`REC_CNT_W-1:0] frames;
    logic [`REC_CNT_W-1:0] drops;
    logic                  recording;
    logic                  limit_hit;

    // ------------------------------------------------------------------
    // capture -> buffer -> writer
    // ------------------------------------------------------------------
    video_capture u_capture (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_pix       (i_pix),
        .i_fval      (i_fval),
        .i_lval      (i_lval),
        .i_ctrl      (ctrl),
        .i_ctrl_wr   (ctrl_wr),
        .o_word      (cap_word),
        .o_word_valid(cap_valid),
        .i_word_ready(cap_ready),
        .o_frames    (frames),
        .o_drops     (drops),
        .o_recording (recording),
        .o_limit_hit (limit_hit)
    );

    stream_fifo #(
        .T    (vid_word_t),
        .DEPTH(`REC_FIFO_DEPTH)
    ) u_vid_fifo (
        .clk    (clk),
        .i_reset(i_reset),
        .i_data (cap_word),
        .i_valid(cap_valid),
        .o_ready(cap_ready),
        .o_data (buf_word),
        .o_valid(buf_valid),
        .i_ready(buf_ready),
        .o_empty(fifo_empty)
    );

    rec_writer u_writer (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_start     (ctrl_wr),
        .i_word      (buf_word),
        .i_word_valid(buf_valid),
        .o_word_ready(buf_ready),
        .o_rec       (o_rec),
        .o_rec_valid (o_rec_valid),
        .i_rec_ready (i_rec_ready)
    );

    // registers
    usr_ctrl_regs u_regs (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_usr_tx_wr (i_usr_tx_wr),
        .i_usr_rx_rd (i_usr_rx_rd),
        .i_usr_txd   (i_usr_txd),
        .o_usr_rxd   (o_usr_rxd),
        .o_usr_status(o_usr_status),
        .o_ctrl      (ctrl),
        .o_ctrl_wr   (ctrl_wr),
        .i_frames    (frames),
        .i_drops     (drops),
        .i_recording (recording),
        .i_limit_hit (limit_hit),
        .i_fifo_empty(fifo_empty)
    );

endmodule

/* dv/tb_rec_top.sv */
`timescale 1ns/100ps
`include "rec_defs.svh"

module tb_rec_top import rec_pkg::*; ();

    localparam int LINES        = 4;
    localparam int LINE_LEN     = 8;       // groups per line
    localparam int HBLANK       = 4;
    localparam int VBLANK       = 6;
    localparam int FRAME_CYC    = 2 + LINES * (LINE_LEN + HBLANK) + VBLANK;
    localparam int NUM_FRAMES   = 13;      // all frames sent over the six tests
    localparam int WATCHDOG_CYC = NUM_FRAMES * FRAME_CYC * 4 + 2000;
    localparam int DRAIN_CYC    = 1000;

    logic        clk = 1'b0;
    logic        i_reset;
    pix_group_t  i_pix;
    logic        i_fval;
    logic        i_lval;
    rec_beat_t   o_rec;
    logic        o_rec_valid;
    logic        i_rec_ready;
    logic        i_usr_tx_wr;
    logic        i_usr_rx_rd;
    cfg_cmd_t    i_usr_txd;
    logic [15:0] o_usr_rxd;
    rec_stat_t   o_usr_status;

    integer      seed = 65;
    vid_word_t   ref_q[$];                   // words expected on the record port
    logic [`REC_ADDR_W-1:0] exp_addr;
    rec_beat_t   exp_beat;
    rec_beat_t   held_beat;
    logic        stalled;
    bit          ready_random;
    int          errors, checks, test_errs, tests_run, tests_bad, test_num;
    string       test_name;

    always #10 clk = ~clk;                   // 20 ns period

    rec_top UUT (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_pix       (i_pix),
        .i_fval      (i_fval),
        .i_lval      (i_lval),
        .o_rec       (o_rec),
        .o_rec_valid (o_rec_valid),
        .i_rec_ready (i_rec_ready),
        .i_usr_tx_wr (i_usr_tx_wr),
        .i_usr_rx_rd (i_usr_rx_rd),
        .i_usr_txd   (i_usr_txd),
        .o_usr_rxd   (o_usr_rxd),
        .o_usr_status(o_usr_status)
    );

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_beat(input string name, input rec_beat_t got, input rec_beat_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic check_rxd(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic check_status(input string name, input rec_stat_t got, input rec_stat_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    // status byte from its fields, upper nibble zero
    function automatic rec_stat_t make_status(input logic rec, input logic ovf,
                                              input logic empty, input logic lim);
        rec_stat_t s;
        s           = '0;
        s.recording = rec;
        s.ovf_seen  = ovf;
        s.empty     = empty;
        s.limit_hit = lim;
        return s;
    endfunction

    // ----------------------------------------------------------------------
    // record port monitor
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!i_reset) begin
            if (stalled)
                check_beat("o_rec held", o_rec, held_beat);   // no change while stalled
            if (o_rec_valid && i_rec_ready) begin
                if (ref_q.size() == 0) begin
                    $display("Error: beat at address %h arrived with no word expected",
                             o_rec.addr);
                    count_error();
                end else begin
                    exp_beat.addr = exp_addr;
                    exp_beat.word = ref_q.pop_front();
                    check_beat("o_rec", o_rec, exp_beat);
                    exp_addr = exp_addr + 1'b1;
                end
            end
            stalled   = o_rec_valid && !i_rec_ready;
            held_beat = o_rec;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic pix_group_t random_group();
        pix_group_t g;
        for (int i = 0; i < `REC_PIX_LANES; i++)
            g[i] = `REC_PIX_W'($random(seed));
        return g;
    endfunction

    // one frame, fval leads the first line by a cycle
    task automatic send_frame(input int lines, input int len, input bit rec);
        vid_word_t w;
        @(posedge clk);
        i_fval <= 1'b1;
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < len; p++) begin
                @(posedge clk);
                w.pix = random_group();
                w.sof = (l == 0) && (p == 0);
                w.sol = (p == 0);
                i_pix  <= w.pix;
                i_lval <= 1'b1;
                if (rec)
                    ref_q.push_back(w);      // expected on the record port
            end
            repeat (HBLANK) begin
                @(posedge clk);
                i_lval <= 1'b0;
            end
        end
        @(posedge clk);
        i_fval <= 1'b0;
        repeat (VBLANK) @(posedge clk);
    endtask

    task automatic write_ctrl(input logic en, input logic [`REC_LIMIT_W-1:0] limit);
        cfg_cmd_t cmd;
        cmd.addr = `REC_REG_CTRL;
        cmd.data = {limit, 3'b000, en};
        if (en)
            exp_addr = '0;                   // writer restarts addresses
        @(posedge clk);
        i_usr_txd   <= cmd;
        i_usr_tx_wr <= 1'b1;
        @(posedge clk);
        i_usr_tx_wr <= 1'b0;
    endtask

    task automatic expect_reg(input logic [3:0] addr, input string name,
                              input logic [15:0] exp);
        cfg_cmd_t cmd;
        cmd.addr = addr;
        cmd.data = '0;
        @(posedge clk);
        i_usr_txd   <= cmd;
        i_usr_rx_rd <= 1'b1;
        @(posedge clk);
        i_usr_rx_rd <= 1'b0;
        @(negedge clk);                      // rxd loaded on the edge before
        check_rxd(name, o_usr_rxd, exp);
    endtask

    task automatic toggle_ready();
        while (ready_random) begin
            @(posedge clk);
            i_rec_ready <= (($random(seed) & 3) != 0);   // ready about 3 of 4 cycles
        end
    endtask

    task automatic wait_drained();
        int  n;
        bit  done;
        n    = 0;
        done = 0;
        while (!done && n < DRAIN_CYC) begin
            @(negedge clk);
            n++;
            done = (ref_q.size() == 0) && !o_rec_valid;
        end
        if (!done) begin
            $display("Error: record port did not drain, %0d words still expected",
                     ref_q.size());
            count_error();
        end
        repeat (8) @(negedge clk);           // room for stray beats
    endtask

    task automatic start_test(input int num, input string name);
        test_num  = num;
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, test_name, test_errs);
            tests_bad++;
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic check_after_reset();
        int high;
        start_test(1, "reset state");
        high = 0;
        repeat (20) begin
            @(negedge clk);
            if (o_rec_valid !== 1'b0)
                high++;
        end
        if (high != 0) begin
            $display("Error: o_rec_valid was high on %0d cycles after reset", high);
            count_error();
        end
        check_status("o_usr_status", o_usr_status, make_status(0, 0, 1, 0));
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd0);
        report_test();
    endtask

    task automatic record_from_next_frame();
        start_test(2, "enable mid-frame");
        fork
            send_frame(LINES, LINE_LEN, 0);  // enable lands inside it
            begin
                repeat (FRAME_CYC / 2) @(posedge clk);
                write_ctrl(1, 0);
            end
        join
        @(negedge clk);
        check_status("o_usr_status", o_usr_status, make_status(1, 0, 1, 0));
        send_frame(LINES, LINE_LEN, 1);
        send_frame(LINES, LINE_LEN, 1);
        write_ctrl(0, 0);
        wait_drained();
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd2);
        report_test();
    endtask

    task automatic stop_at_frame_limit();
        start_test(3, "frame limit 2");
        write_ctrl(1, 2);
        send_frame(LINES, LINE_LEN, 1);
        send_frame(LINES, LINE_LEN, 1);
        send_frame(LINES, LINE_LEN, 0);      // past the limit
        wait_drained();
        check_status("o_usr_status", o_usr_status, make_status(0, 0, 1, 1));
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd2);
        report_test();
    endtask

    task automatic survive_random_stalls();
        start_test(4, "random back-pressure");
        ready_random = 1;
        fork
            toggle_ready();
            begin
                write_ctrl(1, 0);
                send_frame(LINES, LINE_LEN, 1);
                send_frame(LINES, LINE_LEN, 1);
                write_ctrl(0, 0);
                wait_drained();
                ready_random = 0;
            end
        join
        @(posedge clk);
        i_rec_ready <= 1'b1;
        expect_reg(`REC_REG_DROPS, "o_usr_rxd DROPS", 16'd0);
        check_status("o_usr_status", o_usr_status, make_status(0, 0, 1, 0));
        report_test();
    endtask

    task automatic drop_on_overflow();
        start_test(5, "overflow with sink stalled");
        @(posedge clk);
        i_rec_ready <= 1'b0;
        write_ctrl(1, 1);                    // one frame, then stop
        send_frame(LINES, LINE_LEN, 1);
        // buffer plus writer slot keep the earliest words
        while (ref_q.size() > `REC_FIFO_DEPTH + 1)
            void'(ref_q.pop_back());
        repeat (4) @(posedge clk);
        expect_reg(`REC_REG_DROPS, "o_usr_rxd DROPS",
                   16'(LINES * LINE_LEN - (`REC_FIFO_DEPTH + 1)));
        check_status("o_usr_status", o_usr_status, make_status(0, 1, 0, 1));
        @(posedge clk);
        i_rec_ready <= 1'b1;
        wait_drained();
        check_status("o_usr_status", o_usr_status, make_status(0, 1, 1, 1));
        report_test();
    endtask

    task automatic finish_frame_on_disable();
        start_test(6, "disable mid-frame");
        write_ctrl(1, 0);
        send_frame(LINES, LINE_LEN, 1);
        fork
            send_frame(LINES, LINE_LEN, 1);  // still recorded to its end
            begin
                repeat (FRAME_CYC / 2) @(posedge clk);
                write_ctrl(0, 0);
            end
        join
        send_frame(LINES, LINE_LEN, 0);
        wait_drained();
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd2);
        check_status("o_usr_status", o_usr_status, make_status(0, 0, 1, 0));
        write_ctrl(1, 0);                    // fresh run
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd0);
        expect_reg(`REC_REG_DROPS, "o_usr_rxd DROPS", 16'd0);
        send_frame(LINES, LINE_LEN, 1);
        wait_drained();
        write_ctrl(0, 0);
        expect_reg(`REC_REG_FRAMES, "o_usr_rxd FRAMES", 16'd1);
        report_test();
    endtask

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        i_reset      = 1'b1;
        i_pix        = '0;
        i_fval       = 1'b0;
        i_lval       = 1'b0;
        i_rec_ready  = 1'b1;
        i_usr_tx_wr  = 1'b0;
        i_usr_rx_rd  = 1'b0;
        i_usr_txd    = '0;
        exp_addr     = '0;
        stalled      = 1'b0;
        ready_random = 0;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;

        check_after_reset();
        record_from_next_frame();
        stop_at_frame_limit();
        survive_random_stalls();
        drop_on_overflow();
        finish_frame_on_disable();

        $display("tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles in test %0d", WATCHDOG_CYC,
                 test_num);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/rec_pkg.sv
rtl/video_capture.sv
rtl/stream_fifo.sv
rtl/usr_ctrl_regs.sv
rtl/rec_writer.sv
rtl/rec_top.sv
dv/tb_rec_top.sv

/* run.sh */
#!/usr/bin/env bash
# build the recorder testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rec_top \
    -Mdir "$BUILD_DIR" -o tb_rec_top > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_rec_top" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
